//--- flist.f
rtl/dcache_pkg.sv
rtl/dcache_tag_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_frames.sv
rtl/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_tag_lookup.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_frames.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_dcache.sv

//--- tests/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int unsigned IDX_W        = 3;
    localparam int unsigned MEM_WORDS    = 1024;
    localparam int unsigned RESET_CYCLES = 5;
    // Accesses, snoops and the halt in the sequence below
    localparam int unsigned NUM_OPS      = 17;
    localparam int unsigned WORST_CYCLES = 40;
    localparam logic        RD           = 1'b0;
    localparam logic        WR           = 1'b1;

    logic              CLK, nRST;
    logic              dmem_ren, dmem_wen, halt, dhit, flushed;
    dcache_pkg::addr_t dmem_addr, mem_addr, cc_snoop_addr;
    dcache_pkg::word_t dmem_store, dmem_load, mem_store, mem_load;
    logic              mem_ren, mem_wen, mem_wait, cc_wait, cc_inv, cc_write;

    // Shadow memory and bus transfer log
    dcache_pkg::word_t shadow  [MEM_WORDS];
    logic              written [MEM_WORDS];
    dcache_pkg::addr_t rd_addrs [$];
    dcache_pkg::addr_t wr_addrs [$];
    dcache_pkg::word_t wr_data  [$];
    string             test_name;

    dcache_top #(.IDX_W(IDX_W)) i_dut (
        .CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
        .dmem_load, .dhit, .flushed, .mem_ren, .mem_wen, .mem_addr, .mem_store,
        .mem_load, .mem_wait, .cc_wait, .cc_inv, .cc_snoop_addr, .cc_write
    );

    tb_mem_model #(.WORDS(MEM_WORDS), .MAX_WAIT(3)) i_mem (
        .CLK, .nRST, .mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
    );

    function automatic dcache_pkg::word_t initial_word(input dcache_pkg::addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[31:16]};
    endfunction

    // Expected word at a byte address
    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t a);
        return shadow[a[11:2]];
    endfunction

    task automatic check(input string name, input dcache_pkg::word_t expected,
                         input dcache_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic access(input logic wr, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t data);
        @(negedge CLK);
        dmem_ren   = !wr;
        dmem_wen   = wr;
        dmem_addr  = addr;
        dmem_store = data;
        do begin
            @(posedge CLK);
        end while (!dhit);
        @(negedge CLK);
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    // Two reads of one block with word 0 first
    task automatic expect_fill(input dcache_pkg::addr_t blk, input int unsigned first);
        check({test_name, "_rd_count"}, first + 2, rd_addrs.size());
        check({test_name, "_rd_addr0"}, blk, rd_addrs[first]);
        check({test_name, "_rd_addr1"}, blk + 4, rd_addrs[first+1]);
    endtask

    task automatic expect_writeback(input dcache_pkg::addr_t blk, input int unsigned first);
        check({test_name, "_wr_count"}, first + 2, wr_addrs.size());
        check({test_name, "_wr_addr0"}, blk, wr_addrs[first]);
        check({test_name, "_wr_addr1"}, blk + 4, wr_addrs[first+1]);
        check({test_name, "_wr_data0"}, expected_load(blk), wr_data[first]);
        check({test_name, "_wr_data1"}, expected_load(blk + 4), wr_data[first+1]);
    endtask

    // Snoop of a modified line that must be written back
    task automatic snoop(input dcache_pkg::addr_t addr, input logic inv);
        int unsigned first;
        logic        wrote;
        first = wr_addrs.size();
        @(negedge CLK);
        cc_wait       = 1'b1;
        cc_inv        = inv;
        cc_snoop_addr = addr;
        @(posedge CLK);
        wrote = cc_write;
        @(negedge CLK);
        cc_wait = 1'b0;
        cc_inv  = 1'b0;
        check({test_name, "_cc_write"}, 1, wrote);
        while (wr_addrs.size() < first + 2) begin
            @(negedge CLK);
        end
        expect_writeback({addr[31:3], 3'b000}, first);
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Compare completed loads, track stores and log bus transfers
    always @(posedge CLK) begin
        if (nRST && dhit && dmem_ren) begin
            check(test_name, expected_load(dmem_addr), dmem_load);
        end
        if (nRST && dhit && dmem_wen) begin
            shadow[dmem_addr[11:2]]  = dmem_store;
            written[dmem_addr[11:2]] = 1'b1;
        end
        if (nRST && mem_ren && !mem_wait) begin
            rd_addrs.push_back(mem_addr);
        end
        if (nRST && mem_wen && !mem_wait) begin
            wr_addrs.push_back(mem_addr);
            wr_data.push_back(mem_store);
        end
    end

    initial begin
        repeat (NUM_OPS * WORST_CYCLES + RESET_CYCLES) @(posedge CLK);
        $display("Watchdog expired before the test sequence finished");
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    initial begin
        int unsigned first;
        int unsigned seed;
        seed = 32'h0297_5ba9;
        void'($urandom(seed));
        nRST = 1'b0;
        {dmem_ren, dmem_wen, halt, cc_wait, cc_inv} = '0;
        dmem_addr     = '0;
        dmem_store    = '0;
        cc_snoop_addr = '0;
        test_name     = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]  = initial_word(i * 4);
            written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        test_name = "read_miss";
        first = rd_addrs.size();
        access(RD, 32'h104, '0);
        expect_fill(32'h100, first);
        access(RD, 32'h104, '0);
        access(RD, 32'h100, '0);
        check("read_hit_no_bus", first + 2, rd_addrs.size());

        test_name = "store_load";
        access(WR, 32'h104, $urandom());
        access(RD, 32'h104, '0);

        // Three blocks of set 2 with the first one left dirty
        test_name = "dirty_evict";
        access(WR, 32'h010, $urandom());
        access(RD, 32'h050, '0);
        first = wr_addrs.size();
        access(RD, 32'h090, '0);
        expect_writeback(32'h010, first);
        first = rd_addrs.size();
        access(RD, 32'h010, '0);
        expect_fill(32'h010, first);

        test_name = "snoop_inv";
        access(WR, 32'h208, $urandom());
        snoop(32'h208, 1'b1);
        first = rd_addrs.size();
        access(RD, 32'h20c, '0);
        expect_fill(32'h208, first);

        // Without invalidate the line stays readable
        test_name = "snoop_shared";
        access(WR, 32'h31c, $urandom());
        snoop(32'h318, 1'b0);
        first = rd_addrs.size();
        access(RD, 32'h31c, '0);
        check("snoop_shared_hit", first, rd_addrs.size());

        // Dirty lines in both ways of set 0 before the halt
        test_name = "flush";
        access(WR, 32'h040, $urandom());
        @(negedge CLK);
        halt = 1'b1;
        do begin
            @(negedge CLK);
        end while (!flushed);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (written[i]) begin
                check("flush_mem", shadow[i], i_mem.mem[i]);
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter int unsigned WORDS    = 1024,
    parameter int unsigned MAX_WAIT = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::word_t mem_store,
    output dcache_pkg::word_t mem_load,
    output logic              mem_wait
);

    localparam int unsigned AW = $clog2(WORDS);

    dcache_pkg::word_t mem [WORDS];
    int unsigned       wait_cnt;
    logic [AW-1:0]     word_idx;

    // Power-up contents hashed from the full byte address
    function automatic dcache_pkg::word_t fill_value(input dcache_pkg::addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[31:16]};
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = fill_value(i * 4);
        end
    end

    assign word_idx = mem_addr[AW+1:2];
    assign mem_load = mem[word_idx];

    // Stall until the countdown for this transfer has run out
    assign mem_wait = (mem_ren || mem_wen) && (wait_cnt != 0);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 1;
        end else if (mem_ren || mem_wen) begin
            if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                if (mem_wen) begin
                    mem[word_idx] <= mem_store;
                end
                wait_cnt <= $urandom_range(MAX_WAIT);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
    parameter int unsigned IDX_W = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::addr_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  logic              halt,
    output dcache_pkg::word_t dmem_load,
    output logic              dhit,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::addr_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait,
    input  logic              cc_wait,
    input  logic              cc_inv,
    input  dcache_pkg::addr_t cc_snoop_addr,
    output logic              cc_write
);

    localparam int unsigned TAG_W = 32 - IDX_W - dcache_pkg::BYT_OFF_W - dcache_pkg::BLK_OFF_W;

    // Lookup results
    logic [IDX_W-1:0] req_idx, snoop_idx;
    logic [TAG_W-1:0] req_tag, snoop_tag;
    logic             req_word, hit0, hit1, snoop_hit0, snoop_hit1;

    // Frame read ports
    logic [TAG_W-1:0] tag_way0, tag_way1, snoop_tag_way0, snoop_tag_way1, victim_tag;
    logic             valid_way0, valid_way1, snoop_valid_way0, snoop_valid_way1;
    logic             lru_bit, victim_dirty, entry_dirty;

    // Frame select and write strobes
    logic [IDX_W-1:0] sel_idx;
    logic             sel_way, sel_word, data_sel;
    logic             fill_word, fill_line, store_word, set_clean, clear_valid, flip_lru;

    dcache_tag_lookup #(.IDX_W(IDX_W)) i_lookup (
        .dmem_addr, .cc_snoop_addr,
        .tag_way0, .tag_way1, .snoop_tag_way0, .snoop_tag_way1,
        .valid_way0, .valid_way1, .snoop_valid_way0, .snoop_valid_way1,
        .req_idx, .snoop_idx, .req_word, .req_tag, .snoop_tag,
        .hit0, .hit1, .snoop_hit0, .snoop_hit1
    );

    dcache_ctrl #(.IDX_W(IDX_W)) i_ctrl (
        .CLK, .nRST, .dmem_ren, .dmem_wen, .halt, .cc_wait, .cc_inv, .mem_wait,
        .hit0, .hit1, .snoop_hit0, .snoop_hit1, .req_word,
        .req_idx, .snoop_idx, .req_tag, .snoop_tag,
        .lru_bit, .victim_dirty, .victim_tag, .entry_dirty,
        .dhit, .flushed, .mem_ren, .mem_wen, .mem_addr, .cc_write,
        .sel_way, .sel_idx, .sel_word, .data_sel,
        .fill_word, .fill_line, .store_word, .set_clean, .clear_valid, .flip_lru
    );

    dcache_frames #(.IDX_W(IDX_W)) i_frames (
        .CLK, .nRST,
        .fill_word, .fill_line, .store_word, .set_clean, .clear_valid, .flip_lru,
        .sel_way, .sel_idx, .sel_word, .mem_load, .dmem_store,
        .req_idx, .snoop_idx, .req_tag, .data_sel,
        .dmem_load, .mem_store,
        .tag_way0, .tag_way1, .snoop_tag_way0, .snoop_tag_way1,
        .valid_way0, .valid_way1, .snoop_valid_way0, .snoop_valid_way1,
        .lru_bit, .victim_dirty, .victim_tag, .entry_dirty
    );

endmodule

`default_nettype wire

//--- rtl/dcache_frames.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_frames #(
    parameter int unsigned IDX_W = 3,
    localparam int unsigned TAG_W = 32 - IDX_W - dcache_pkg::BYT_OFF_W - dcache_pkg::BLK_OFF_W
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              fill_word,
    input  logic              fill_line,
    input  logic              store_word,
    input  logic              set_clean,
    input  logic              clear_valid,
    input  logic              flip_lru,
    input  logic              sel_way,
    input  logic [IDX_W-1:0]  sel_idx,
    input  logic              sel_word,
    input  dcache_pkg::word_t mem_load,
    input  dcache_pkg::word_t dmem_store,
    input  logic [IDX_W-1:0]  req_idx,
    input  logic [IDX_W-1:0]  snoop_idx,
    input  logic [TAG_W-1:0]  req_tag,
    input  logic              data_sel,
    output dcache_pkg::word_t dmem_load,
    output dcache_pkg::word_t mem_store,
    output logic [TAG_W-1:0]  tag_way0,
    output logic [TAG_W-1:0]  tag_way1,
    output logic [TAG_W-1:0]  snoop_tag_way0,
    output logic [TAG_W-1:0]  snoop_tag_way1,
    output logic              valid_way0,
    output logic              valid_way1,
    output logic              snoop_valid_way0,
    output logic              snoop_valid_way1,
    output logic              lru_bit,
    output logic              victim_dirty,
    output logic [TAG_W-1:0]  victim_tag,
    output logic              entry_dirty
);

    localparam int unsigned SETS = 2 ** IDX_W;

    logic [SETS-1:0]   valid_q [dcache_pkg::NUM_WAYS];
    logic [SETS-1:0]   dirty_q [dcache_pkg::NUM_WAYS];
    logic [SETS-1:0]   lru_q;
    logic [TAG_W-1:0]  tag_q   [dcache_pkg::NUM_WAYS][SETS];
    dcache_pkg::word_t data_q  [dcache_pkg::NUM_WAYS][SETS][dcache_pkg::WORDS_PER_BLK];

    // Coherence state and LRU; later strobes win on the same entry
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (fill_line) begin
                valid_q[sel_way][sel_idx] <= 1'b1;
                dirty_q[sel_way][sel_idx] <= 1'b0;
            end
            if (store_word) begin
                dirty_q[sel_way][sel_idx] <= 1'b1;
            end
            if (set_clean) begin
                dirty_q[sel_way][sel_idx] <= 1'b0;
            end
            if (clear_valid) begin
                valid_q[sel_way][sel_idx] <= 1'b0;
            end
            if (flip_lru) begin
                lru_q[sel_idx] <= ~lru_q[sel_idx];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_line) begin
            tag_q[sel_way][sel_idx] <= req_tag;
        end
        if (fill_word) begin
            data_q[sel_way][sel_idx][sel_word] <= mem_load;
        end else if (store_word) begin
            data_q[sel_way][sel_idx][sel_word] <= dmem_store;
        end
    end

    // Request port
    assign tag_way0   = tag_q[0][req_idx];
    assign tag_way1   = tag_q[1][req_idx];
    assign valid_way0 = valid_q[0][req_idx];
    assign valid_way1 = valid_q[1][req_idx];

    // Snoop port
    assign snoop_tag_way0   = tag_q[0][snoop_idx];
    assign snoop_tag_way1   = tag_q[1][snoop_idx];
    assign snoop_valid_way0 = valid_q[0][snoop_idx];
    assign snoop_valid_way1 = valid_q[1][snoop_idx];

    // Replacement candidate of the requested set
    assign lru_bit      = lru_q[req_idx];
    assign victim_dirty = dirty_q[lru_q[req_idx]][req_idx];

    // Selected entry which is the victim during write-back or the line being flushed
    assign victim_tag  = tag_q[sel_way][sel_idx];
    assign entry_dirty = dirty_q[sel_way][sel_idx];

    assign dmem_load = data_q[data_sel][req_idx][sel_word];
    assign mem_store = data_q[sel_way][sel_idx][sel_word];

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
    parameter int unsigned IDX_W = 3,
    localparam int unsigned TAG_W = 32 - IDX_W - dcache_pkg::BYT_OFF_W - dcache_pkg::BLK_OFF_W
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              halt,
    input  logic              cc_wait,
    input  logic              cc_inv,
    input  logic              mem_wait,
    input  logic              hit0,
    input  logic              hit1,
    input  logic              snoop_hit0,
    input  logic              snoop_hit1,
    input  logic              req_word,
    input  logic [IDX_W-1:0]  req_idx,
    input  logic [IDX_W-1:0]  snoop_idx,
    input  logic [TAG_W-1:0]  req_tag,
    input  logic [TAG_W-1:0]  snoop_tag,
    input  logic              lru_bit,
    input  logic              victim_dirty,
    input  logic [TAG_W-1:0]  victim_tag,
    input  logic              entry_dirty,
    output logic              dhit,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::addr_t mem_addr,
    output logic              cc_write,
    output logic              sel_way,
    output logic [IDX_W-1:0]  sel_idx,
    output logic              sel_word,
    output logic              data_sel,
    output logic              fill_word,
    output logic              fill_line,
    output logic              store_word,
    output logic              set_clean,
    output logic              clear_valid,
    output logic              flip_lru
);

    localparam logic [dcache_pkg::BYT_OFF_W-1:0] BYTE_ZERO = '0;

    typedef enum logic [3:0] {
        COMPARE, ALLOC1, ALLOC2, WB1, WB2, SNOOP_WB1, SNOOP_WB2,
        FLUSH_INIT, FLUSH_SCAN, FLUSH_WD0, FLUSH_WD1, FLUSH_DONE
    } cache_state_e;

    cache_state_e state, next_state;
    // Flush position with the way in the top bit and the set below it
    logic [IDX_W:0] flush_cnt, next_flush_cnt;
    logic snoop_way, next_snoop_way;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= COMPARE;
            flush_cnt <= '0;
            snoop_way <= 1'b0;
        end else begin
            state     <= next_state;
            flush_cnt <= next_flush_cnt;
            snoop_way <= next_snoop_way;
        end
    end

    // Frame entry that the write strobes act on
    always_comb begin
        sel_way  = hit1;
        sel_idx  = req_idx;
        sel_word = req_word;
        data_sel = hit1;
        case (state)
            COMPARE: begin
                if (cc_wait) begin
                    sel_way = snoop_hit1;
                    sel_idx = snoop_idx;
                end
            end
            ALLOC1, WB1: begin
                sel_way  = lru_bit;
                sel_word = 1'b0;
            end
            ALLOC2, WB2: begin
                sel_way  = lru_bit;
                sel_word = 1'b1;
            end
            SNOOP_WB1, SNOOP_WB2: begin
                sel_way  = snoop_way;
                sel_idx  = snoop_idx;
                sel_word = (state == SNOOP_WB2);
            end
            FLUSH_SCAN, FLUSH_WD0, FLUSH_WD1: begin
                sel_way  = flush_cnt[IDX_W];
                sel_idx  = flush_cnt[IDX_W-1:0];
                sel_word = (state == FLUSH_WD1);
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state     = state;
        next_flush_cnt = flush_cnt;
        next_snoop_way = snoop_way;
        dhit        = 1'b0;
        flushed     = 1'b0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        cc_write    = 1'b0;
        fill_word   = 1'b0;
        fill_line   = 1'b0;
        store_word  = 1'b0;
        set_clean   = 1'b0;
        clear_valid = 1'b0;
        flip_lru    = 1'b0;

        case (state)
            COMPARE: begin
                if (cc_wait) begin
                    // Snoop first; a modified hit drops to S or I and writes back
                    if (snoop_hit0 || snoop_hit1) begin
                        clear_valid = cc_inv;
                        if (entry_dirty) begin
                            cc_write       = 1'b1;
                            set_clean      = 1'b1;
                            next_snoop_way = snoop_hit1;
                            next_state     = SNOOP_WB1;
                        end
                    end
                end else if (halt) begin
                    next_state = FLUSH_INIT;
                end else if (dmem_ren || dmem_wen) begin
                    if (hit0 || hit1) begin
                        dhit = 1'b1;
                        // Point LRU away from the way just used
                        flip_lru = (lru_bit == hit1);
                        if (dmem_wen) begin
                            store_word = 1'b1;
                            cc_write   = 1'b1;
                        end
                    end else begin
                        next_state = victim_dirty ? WB1 : ALLOC1;
                    end
                end
            end
            ALLOC1, ALLOC2: begin
                mem_ren  = 1'b1;
                mem_addr = {req_tag, req_idx, sel_word, BYTE_ZERO};
                if (!mem_wait) begin
                    fill_word = 1'b1;
                    if (state == ALLOC1) begin
                        next_state = ALLOC2;
                    end else begin
                        fill_line  = 1'b1;
                        flip_lru   = 1'b1;
                        next_state = COMPARE;
                    end
                end
            end
            WB1, WB2: begin
                mem_wen  = 1'b1;
                mem_addr = {victim_tag, req_idx, sel_word, BYTE_ZERO};
                if (!mem_wait) begin
                    next_state = (state == WB1) ? WB2 : ALLOC1;
                end
            end
            SNOOP_WB1, SNOOP_WB2: begin
                cc_write = 1'b1;
                mem_wen  = 1'b1;
                mem_addr = {snoop_tag, snoop_idx, sel_word, BYTE_ZERO};
                if (!mem_wait) begin
                    next_state = (state == SNOOP_WB1) ? SNOOP_WB2 : COMPARE;
                end
            end
            FLUSH_INIT: begin
                next_flush_cnt = '0;
                next_state     = FLUSH_SCAN;
            end
            FLUSH_SCAN: begin
                // Skip clean entries and walk way 0 sets before way 1 sets
                if (entry_dirty) begin
                    next_state = FLUSH_WD0;
                end else if (&flush_cnt) begin
                    next_state = FLUSH_DONE;
                end else begin
                    next_flush_cnt = flush_cnt + 1'b1;
                end
            end
            FLUSH_WD0, FLUSH_WD1: begin
                mem_wen  = 1'b1;
                mem_addr = {victim_tag, sel_idx, sel_word, BYTE_ZERO};
                if (!mem_wait) begin
                    if (state == FLUSH_WD0) begin
                        next_state = FLUSH_WD1;
                    end else begin
                        set_clean = 1'b1;
                        if (&flush_cnt) begin
                            next_state = FLUSH_DONE;
                        end else begin
                            next_flush_cnt = flush_cnt + 1'b1;
                            next_state     = FLUSH_SCAN;
                        end
                    end
                end
            end
            FLUSH_DONE: begin
                flushed = 1'b1;
            end
            default: next_state = COMPARE;
        endcase
    end

    bus_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
    else $error("Bus read and write requested together");

    bus_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr))
    else $error("Bus address changed while mem_wait was high");

endmodule

`default_nettype wire

//--- rtl/dcache_tag_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_lookup #(
    parameter int unsigned IDX_W = 3,
    localparam int unsigned TAG_W = 32 - IDX_W - dcache_pkg::BYT_OFF_W - dcache_pkg::BLK_OFF_W
) (
    input  dcache_pkg::addr_t dmem_addr,
    input  dcache_pkg::addr_t cc_snoop_addr,
    input  logic [TAG_W-1:0]  tag_way0,
    input  logic [TAG_W-1:0]  tag_way1,
    input  logic [TAG_W-1:0]  snoop_tag_way0,
    input  logic [TAG_W-1:0]  snoop_tag_way1,
    input  logic              valid_way0,
    input  logic              valid_way1,
    input  logic              snoop_valid_way0,
    input  logic              snoop_valid_way1,
    output logic [IDX_W-1:0]  req_idx,
    output logic [IDX_W-1:0]  snoop_idx,
    output logic              req_word,
    output logic [TAG_W-1:0]  req_tag,
    output logic [TAG_W-1:0]  snoop_tag,
    output logic              hit0,
    output logic              hit1,
    output logic              snoop_hit0,
    output logic              snoop_hit1
);

    localparam int unsigned IDX_LSB = dcache_pkg::BYT_OFF_W + dcache_pkg::BLK_OFF_W;

    // Address fields from the tag down to the byte offset
    assign req_tag   = dmem_addr[31 -: TAG_W];
    assign req_idx   = dmem_addr[IDX_LSB +: IDX_W];
    assign req_word  = dmem_addr[dcache_pkg::BYT_OFF_W];

    assign snoop_tag = cc_snoop_addr[31 -: TAG_W];
    assign snoop_idx = cc_snoop_addr[IDX_LSB +: IDX_W];

    // Datapath compare against both ways of the set
    assign hit0 = valid_way0 && (tag_way0 == req_tag);
    assign hit1 = valid_way1 && (tag_way1 == req_tag);

    // Snoop compare on the second read port
    assign snoop_hit0 = snoop_valid_way0 && (snoop_tag_way0 == snoop_tag);
    assign snoop_hit1 = snoop_valid_way1 && (snoop_tag_way1 == snoop_tag);

    // A block lives in at most one way; a double hit means the fill logic
    // placed the same tag twice in one set
    no_double_hit: assert final (
        $isunknown({hit0, hit1, snoop_hit0, snoop_hit1}) ||
        (!(hit0 && hit1) && !(snoop_hit0 && snoop_hit1))
    ) else $error("Block present in both ways of a set");

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Data word moved between datapath, cache and memory
    typedef logic [31:0] word_t;

    // Byte address as seen on the datapath and the memory bus
    typedef logic [31:0] addr_t;

    // Byte offset inside a word
    localparam int unsigned BYT_OFF_W = 2;

    // Word offset inside a block
    localparam int unsigned BLK_OFF_W = 1;

    // Words held by one frame
    localparam int unsigned WORDS_PER_BLK = 2 ** BLK_OFF_W;

    // Associativity, tied to the single LRU bit per set
    localparam int unsigned NUM_WAYS = 2;

endpackage

`default_nettype wire
